// ==== rtl/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path and address width
`define RV_XLEN 32

// register index width and number of architectural registers
`define RV_REG_ADDR_W 5
`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// sequential step and link increment
`define RV_IMM_FOUR 32'd4

`endif

// ==== rtl/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_REG    = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_RF     = 2'd0,
		FWD_EX_MEM = 2'd1,
		FWD_MEM_WB = 2'd2
	} fwd_sel_e;

	// all zero is a bubble
	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    alu_src_imm;
		logic    branch;
		logic    link;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t                      ctrl;
		logic [`RV_XLEN-1:0]        pc;
		logic [`RV_XLEN-1:0]        rs1_data;
		logic [`RV_XLEN-1:0]        rs2_data;
		logic [`RV_XLEN-1:0]        imm;
		logic [`RV_REG_ADDR_W-1:0]  rs1;
		logic [`RV_REG_ADDR_W-1:0]  rs2;
		logic [`RV_REG_ADDR_W-1:0]  rd;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                      ctrl;
		logic [`RV_XLEN-1:0]        alu_result;
		logic [`RV_XLEN-1:0]        store_data;
		logic [`RV_XLEN-1:0]        branch_target;
		logic                       zero;
		logic [`RV_REG_ADDR_W-1:0]  rd;
	} ex_mem_t;

	typedef struct packed {
		logic                       reg_write;
		logic                       mem_to_reg;
		logic [`RV_REG_ADDR_W-1:0]  rd;
		logic [`RV_XLEN-1:0]        alu_result;
		logic [`RV_XLEN-1:0]        load_data;
	} mem_wb_t;

	// register file write port
	typedef struct packed {
		logic                       we;
		logic [`RV_REG_ADDR_W-1:0]  addr;
		logic [`RV_XLEN-1:0]        data;
	} reg_wr_t;

endpackage

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_stage import rv_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  logic                stall,
	input  logic                flush_id,
	input  logic                redirect,
	input  logic [`RV_XLEN-1:0] redirect_pc,
	input  logic [`RV_XLEN-1:0] instr,
	output logic [`RV_XLEN-1:0] instr_addr,
	output logic [`RV_XLEN-1:0] if_id_instr,
	output logic [`RV_XLEN-1:0] if_id_pc
);

	logic [`RV_XLEN-1:0] pc_next;

	// a redirect overrides a load-use hold
	always_comb begin
		if (redirect) begin
			pc_next = redirect_pc;
		end else if (stall) begin
			pc_next = instr_addr;
		end else begin
			pc_next = instr_addr + `RV_IMM_FOUR;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			instr_addr <= `RV_RESET_PC;
		end else begin
			instr_addr <= pc_next;
		end
	end

	// IF/ID register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			if_id_instr <= `RV_NOP;
			if_id_pc    <= `RV_RESET_PC;
		end else if (flush_id) begin
			if_id_instr <= `RV_NOP;
		end else if (!stall) begin
			if_id_instr <= instr;
			if_id_pc    <= instr_addr;
		end
	end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module decode_stage import rv_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [`RV_XLEN-1:0]        if_id_instr,
	input  logic [`RV_XLEN-1:0]        if_id_pc,
	input  logic [`RV_XLEN-1:0]        rs1_data,
	input  logic [`RV_XLEN-1:0]        rs2_data,
	input  logic                       stall,
	input  logic                       flush_ex,
	output logic [`RV_REG_ADDR_W-1:0]  rs1,
	output logic [`RV_REG_ADDR_W-1:0]  rs2,
	output logic                       jal_redirect,
	output logic [`RV_XLEN-1:0]        jal_target,
	output id_ex_t                     id_ex
);

	logic [6:0]                funct7;
	logic [2:0]                funct3;
	logic [`RV_REG_ADDR_W-1:0] rd;
	logic [`RV_XLEN-1:0]       imm_i;
	logic [`RV_XLEN-1:0]       imm_s;
	logic [`RV_XLEN-1:0]       imm_b;
	logic [`RV_XLEN-1:0]       imm_j;
	logic [`RV_XLEN-1:0]       imm;
	logic                      use_rs1;
	logic                      use_rs2;
	ctrl_t                     ctrl;

	assign funct7 = if_id_instr[31:25];
	assign funct3 = if_id_instr[14:12];

	assign imm_i = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
	assign imm_s = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
	assign imm_b = {{19{if_id_instr[31]}}, if_id_instr[31], if_id_instr[7],
		if_id_instr[30:25], if_id_instr[11:8], 1'b0};
	assign imm_j = {{11{if_id_instr[31]}}, if_id_instr[31], if_id_instr[19:12],
		if_id_instr[20], if_id_instr[30:21], 1'b0};

	// anything not recognized stays a bubble
	always_comb begin
		ctrl    = '0;
		imm     = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode_e'(if_id_instr[6:0]))
			OP_REG: begin
				use_rs1        = 1'b1;
				use_rs2        = 1'b1;
				ctrl.reg_write = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'b000}: ctrl.alu_op = ALU_ADD;
					{7'h20, 3'b000}: ctrl.alu_op = ALU_SUB;
					{7'h00, 3'b111}: ctrl.alu_op = ALU_AND;
					{7'h00, 3'b110}: ctrl.alu_op = ALU_OR;
					{7'h00, 3'b100}: ctrl.alu_op = ALU_XOR;
					{7'h00, 3'b010}: ctrl.alu_op = ALU_SLT;
					default: begin
						ctrl    = '0;
						use_rs1 = 1'b0;
						use_rs2 = 1'b0;
					end
				endcase
			end
			OP_IMM: begin
				if (funct3 == 3'b000) begin
					use_rs1          = 1'b1;
					ctrl.reg_write   = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					imm              = imm_i;
				end
			end
			OP_LOAD: begin
				// word loads only
				if (funct3 == 3'b010) begin
					use_rs1          = 1'b1;
					ctrl.reg_write   = 1'b1;
					ctrl.mem_read    = 1'b1;
					ctrl.mem_to_reg  = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					imm              = imm_i;
				end
			end
			OP_STORE: begin
				if (funct3 == 3'b010) begin
					use_rs1          = 1'b1;
					use_rs2          = 1'b1;
					ctrl.mem_write   = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					imm              = imm_s;
				end
			end
			OP_BRANCH: begin
				// beq compares through a subtract
				if (funct3 == 3'b000) begin
					use_rs1     = 1'b1;
					use_rs2     = 1'b1;
					ctrl.branch = 1'b1;
					ctrl.alu_op = ALU_SUB;
					imm         = imm_b;
				end
			end
			OP_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.link      = 1'b1;
				imm            = imm_j;
			end
			default: begin
			end
		endcase
	end

	// unused sources read as x0 so they never trigger a hazard
	assign rs1 = use_rs1 ? if_id_instr[19:15] : '0;
	assign rs2 = use_rs2 ? if_id_instr[24:20] : '0;
	assign rd  = ctrl.reg_write ? if_id_instr[11:7] : '0;

	assign jal_redirect = ctrl.link;
	assign jal_target   = if_id_pc + imm_j;

	// ID/EX register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_ex <= '0;
		end else if (stall || flush_ex) begin
			id_ex <= '0;
		end else begin
			id_ex.ctrl     <= ctrl;
			id_ex.pc       <= if_id_pc;
			id_ex.rs1_data <= rs1_data;
			id_ex.rs2_data <= rs2_data;
			id_ex.imm      <= imm;
			id_ex.rs1      <= rs1;
			id_ex.rs2      <= rs2;
			id_ex.rd       <= rd;
		end
	end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file import rv_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [`RV_REG_ADDR_W-1:0]  rs1,
	input  logic [`RV_REG_ADDR_W-1:0]  rs2,
	output logic [`RV_XLEN-1:0]        rs1_data,
	output logic [`RV_XLEN-1:0]        rs2_data,
	input  reg_wr_t                    wb
);

	// x0 has no storage
	logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

	function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_ADDR_W-1:0] idx);
		logic [`RV_XLEN-1:0] value;
		if (idx == '0) begin
			value = '0;
		end else if (wb.we && wb.addr == idx) begin
			value = wb.data;
		end else begin
			value = regs[idx];
		end
		return value;
	endfunction

	assign rs1_data = read_port(rs1);
	assign rs2_data = read_port(rs2);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && wb.addr != '0) begin
			regs[wb.addr] <= wb.data;
		end
	end

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module hazard_unit import rv_pkg::*; (
	input  logic [`RV_REG_ADDR_W-1:0]  rs1,
	input  logic [`RV_REG_ADDR_W-1:0]  rs2,
	input  id_ex_t                     id_ex,
	input  ex_mem_t                    ex_mem,
	input  mem_wb_t                    mem_wb,
	input  logic                       jal_redirect,
	input  logic [`RV_XLEN-1:0]        jal_target,
	output logic                       stall,
	output logic                       flush_id,
	output logic                       flush_ex,
	output logic                       flush_mem,
	output logic                       redirect,
	output logic [`RV_XLEN-1:0]        redirect_pc,
	output fwd_sel_e                   fwd_a,
	output fwd_sel_e                   fwd_b
);

	logic branch_taken;

	// younger result wins, x0 is never forwarded
	function automatic fwd_sel_e pick_source(input logic [`RV_REG_ADDR_W-1:0] src);
		fwd_sel_e sel;
		if (src != '0 && ex_mem.ctrl.reg_write && ex_mem.rd == src) begin
			sel = FWD_EX_MEM;
		end else if (src != '0 && mem_wb.reg_write && mem_wb.rd == src) begin
			sel = FWD_MEM_WB;
		end else begin
			sel = FWD_RF;
		end
		return sel;
	endfunction

	assign fwd_a = pick_source(id_ex.rs1);
	assign fwd_b = pick_source(id_ex.rs2);

	// load in EX feeding the instruction in decode
	assign stall = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
		(id_ex.rd == rs1 || id_ex.rd == rs2);

	assign branch_taken = ex_mem.ctrl.branch && ex_mem.zero;

	assign redirect    = branch_taken || jal_redirect;
	assign redirect_pc = branch_taken ? ex_mem.branch_target : jal_target;

	// taken beq squashes IF/ID, ID/EX and the instruction in EX
	assign flush_id  = redirect;
	assign flush_ex  = branch_taken;
	assign flush_mem = branch_taken;

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module execute_stage import rv_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  id_ex_t              id_ex,
	input  fwd_sel_e            fwd_a,
	input  fwd_sel_e            fwd_b,
	input  logic [`RV_XLEN-1:0] ex_mem_fwd,
	input  logic [`RV_XLEN-1:0] wb_fwd,
	input  logic                flush_mem,
	output logic                data_ren,
	output logic [`RV_XLEN-1:0] load_addr,
	output ex_mem_t             ex_mem
);

	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] alu_b;
	logic [`RV_XLEN-1:0] alu_out;
	logic [`RV_XLEN-1:0] result;
	logic [`RV_XLEN-1:0] branch_target;

	function automatic logic [`RV_XLEN-1:0] fwd_mux(
		input fwd_sel_e            sel,
		input logic [`RV_XLEN-1:0] rf_value
	);
		logic [`RV_XLEN-1:0] value;
		case (sel)
			FWD_EX_MEM: value = ex_mem_fwd;
			FWD_MEM_WB: value = wb_fwd;
			default:    value = rf_value;
		endcase
		return value;
	endfunction

	assign op_a  = fwd_mux(fwd_a, id_ex.rs1_data);
	assign op_b  = fwd_mux(fwd_b, id_ex.rs2_data);
	assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_SUB: alu_out = op_a - alu_b;
			ALU_AND: alu_out = op_a & alu_b;
			ALU_OR:  alu_out = op_a | alu_b;
			ALU_XOR: alu_out = op_a ^ alu_b;
			ALU_SLT: alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			default: alu_out = op_a + alu_b;
		endcase
	end

	// jal writes its return address instead of the ALU output
	assign result        = id_ex.ctrl.link ? id_ex.pc + `RV_IMM_FOUR : alu_out;
	assign branch_target = id_ex.pc + id_ex.imm;

	// read address leaves now, data returns during MEM
	assign load_addr = alu_out;
	assign data_ren  = id_ex.ctrl.mem_read && !flush_mem;

	// EX/MEM register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_mem <= '0;
		end else if (flush_mem) begin
			ex_mem <= '0;
		end else begin
			ex_mem.ctrl          <= id_ex.ctrl;
			ex_mem.alu_result    <= result;
			ex_mem.store_data    <= op_b;
			ex_mem.branch_target <= branch_target;
			ex_mem.zero          <= (alu_out == '0);
			ex_mem.rd            <= id_ex.rd;
		end
	end

endmodule

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module writeback_stage import rv_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  ex_mem_t             ex_mem,
	input  logic [`RV_XLEN-1:0] data_rdata,
	output mem_wb_t             mem_wb,
	output logic [`RV_XLEN-1:0] wb_data
);

	// MEM/WB register, load data arrives during the memory stage
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			mem_wb <= '0;
		end else begin
			mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
			mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
			mem_wb.rd         <= ex_mem.rd;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.load_data  <= data_rdata;
		end
	end

	assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core import rv_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	output logic [`RV_XLEN-1:0] instr_addr,
	input  logic [`RV_XLEN-1:0] instr,
	output logic [`RV_XLEN-1:0] data_addr,
	output logic [`RV_XLEN-1:0] data_wdata,
	input  logic [`RV_XLEN-1:0] data_rdata,
	output logic                data_ren,
	output logic                data_wen
);

	logic [`RV_XLEN-1:0]       if_id_instr;
	logic [`RV_XLEN-1:0]       if_id_pc;
	logic [`RV_REG_ADDR_W-1:0] rs1;
	logic [`RV_REG_ADDR_W-1:0] rs2;
	logic [`RV_XLEN-1:0]       rs1_data;
	logic [`RV_XLEN-1:0]       rs2_data;
	logic                      jal_redirect;
	logic [`RV_XLEN-1:0]       jal_target;
	logic                      stall;
	logic                      flush_id;
	logic                      flush_ex;
	logic                      flush_mem;
	logic                      redirect;
	logic [`RV_XLEN-1:0]       redirect_pc;
	fwd_sel_e                  fwd_a;
	fwd_sel_e                  fwd_b;
	logic [`RV_XLEN-1:0]       load_addr;
	logic [`RV_XLEN-1:0]       wb_data;
	id_ex_t                    id_ex;
	ex_mem_t                   ex_mem;
	mem_wb_t                   mem_wb;
	reg_wr_t                   wb_write;

	// loads address from EX, stores from the EX/MEM register
	assign data_addr  = data_ren ? load_addr : ex_mem.alu_result;
	assign data_wen   = ex_mem.ctrl.mem_write;
	assign data_wdata = ex_mem.store_data;

	assign wb_write.we   = mem_wb.reg_write;
	assign wb_write.addr = mem_wb.rd;
	assign wb_write.data = wb_data;

	fetch_stage u_fetch (
		.clock       (clock),
		.reset       (reset),
		.stall       (stall),
		.flush_id    (flush_id),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.if_id_instr (if_id_instr),
		.if_id_pc    (if_id_pc)
	);

	decode_stage u_decode (
		.clock        (clock),
		.reset        (reset),
		.if_id_instr  (if_id_instr),
		.if_id_pc     (if_id_pc),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.stall        (stall),
		.flush_ex     (flush_ex),
		.rs1          (rs1),
		.rs2          (rs2),
		.jal_redirect (jal_redirect),
		.jal_target   (jal_target),
		.id_ex        (id_ex)
	);

	reg_file u_reg_file (
		.clock    (clock),
		.reset    (reset),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb       (wb_write)
	);

	hazard_unit u_hazard (
		.rs1          (rs1),
		.rs2          (rs2),
		.id_ex        (id_ex),
		.ex_mem       (ex_mem),
		.mem_wb       (mem_wb),
		.jal_redirect (jal_redirect),
		.jal_target   (jal_target),
		.stall        (stall),
		.flush_id     (flush_id),
		.flush_ex     (flush_ex),
		.flush_mem    (flush_mem),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b)
	);

	execute_stage u_execute (
		.clock      (clock),
		.reset      (reset),
		.id_ex      (id_ex),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b),
		.ex_mem_fwd (ex_mem.alu_result),
		.wb_fwd     (wb_data),
		.flush_mem  (flush_mem),
		.data_ren   (data_ren),
		.load_addr  (load_addr),
		.ex_mem     (ex_mem)
	);

	writeback_stage u_writeback (
		.clock      (clock),
		.reset      (reset),
		.ex_mem     (ex_mem),
		.data_rdata (data_rdata),
		.mem_wb     (mem_wb),
		.wb_data    (wb_data)
	);

endmodule

// ==== dv/tb_memory.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_memory (
	input  logic                clock,
	input  logic [`RV_XLEN-1:0] instr_addr,
	output logic [`RV_XLEN-1:0] instr,
	input  logic [`RV_XLEN-1:0] data_addr,
	input  logic [`RV_XLEN-1:0] data_wdata,
	input  logic                data_ren,
	input  logic                data_wen,
	output logic [`RV_XLEN-1:0] data_rdata
);

	localparam int ROM_WORDS = 64;
	localparam int RAM_WORDS = 256;
	localparam logic [`RV_XLEN-1:0] ROM_BYTES = 32'd256;

	// program words, loaded by the testbench top before reset is released
	logic [`RV_XLEN-1:0] rom [ROM_WORDS];
	logic [`RV_XLEN-1:0] ram [RAM_WORDS];
	logic [`RV_XLEN-1:0] read_pending;

	// fetches past the end of the ROM see a nop
	function automatic logic [`RV_XLEN-1:0] fetch_word(input logic [`RV_XLEN-1:0] addr);
		logic [`RV_XLEN-1:0] word;
		if (addr < ROM_BYTES) begin
			word = rom[addr[7:2]];
		end else begin
			word = `RV_NOP;
		end
		return word;
	endfunction

	initial begin : drive_memories
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram[i] = '0;
		end
		instr        = `RV_NOP;
		data_rdata   = '0;
		read_pending = '0;
		forever begin
			@(negedge clock);
			if (data_wen) begin
				ram[data_addr[9:2]] = data_wdata;
			end
			// read data shows up one cycle after the strobe
			data_rdata = read_pending;
			if (data_ren) begin
				read_pending = ram[data_addr[9:2]];
			end else begin
				read_pending = '0;
			end
			// instruction side answers within the same cycle
			instr = fetch_word(instr_addr);
		end
	end

endmodule

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;

	localparam int CLOCK_PERIOD    = 20;
	localparam int RESET_CYCLES    = 10;
	localparam int PROG_LEN        = 33;
	localparam int ROM_WORDS       = 64;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + PROG_LEN * 10;
	localparam int NUM_STORES      = 11;

	// word indices of the control transfers in the program
	localparam int BEQ_TARGET_IDX = 25;
	localparam int JAL_IDX        = 27;
	localparam int JAL_TARGET_IDX = 30;
	localparam logic [`RV_XLEN-1:0] LOAD_ADDR = 32'h0000_0100;

	logic                clock;
	logic                reset;
	logic [`RV_XLEN-1:0] instr_addr;
	logic [`RV_XLEN-1:0] instr;
	logic [`RV_XLEN-1:0] data_addr;
	logic [`RV_XLEN-1:0] data_wdata;
	logic [`RV_XLEN-1:0] data_rdata;
	logic                data_ren;
	logic                data_wen;

	logic [`RV_XLEN-1:0] prog [PROG_LEN];
	logic [`RV_XLEN-1:0] exp_addr [16];
	logic [`RV_XLEN-1:0] exp_data [16];
	logic [`RV_XLEN-1:0] want_addr;
	logic [`RV_XLEN-1:0] want_data;
	logic [3:0]          store_count;
	logic [`RV_XLEN-1:0] val_a;
	logic [`RV_XLEN-1:0] val_b;
	logic [`RV_XLEN-1:0] val_c;
	logic [`RV_XLEN-1:0] link_value;
	bit                  failed;

	// instruction encoders
	function automatic logic [31:0] alu_reg(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// differing signs decide by the sign bit alone
	function automatic logic [31:0] less_signed(input logic [31:0] a, input logic [31:0] b);
		logic less;
		if (a[31] != b[31]) begin
			less = a[31];
		end else begin
			less = a < b;
		end
		return {31'b0, less};
	endfunction

	// taken beq and jal are the only legal jumps
	function automatic bit is_redirect_target(input logic [`RV_XLEN-1:0] addr);
		return addr == 32'(BEQ_TARGET_IDX * 4) || addr == 32'(JAL_TARGET_IDX * 4);
	endfunction

	task automatic report_failure(input string msg);
		failed = 1'b1;
		$display("Fail at %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	rv_core u_dut (
		.clock      (clock),
		.reset      (reset),
		.instr_addr (instr_addr),
		.instr      (instr),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_rdata (data_rdata),
		.data_ren   (data_ren),
		.data_wen   (data_wen)
	);

	tb_memory u_mem (
		.clock      (clock),
		.instr_addr (instr_addr),
		.instr      (instr),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_ren   (data_ren),
		.data_wen   (data_wen),
		.data_rdata (data_rdata)
	);

	initial begin : clock_gen
		clock = 1'b0;
		forever begin
			#(CLOCK_PERIOD / 2) clock = ~clock;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			store_count <= '0;
		end else if (data_wen) begin
			store_count <= store_count + 4'd1;
		end
	end

	assign want_addr = exp_addr[store_count];
	assign want_data = exp_data[store_count];

	initial begin : run_setup
		logic [11:0] imm_a;
		logic [11:0] imm_b;
		logic [11:0] imm_c;
		failed = 1'b0;
		reset  = 1'b0;
		void'($urandom(56));
		imm_a = 12'($urandom_range(4095, 0));
		imm_b = 12'($urandom_range(4095, 0));
		imm_c = 12'($urandom_range(4095, 0));
		// the not-taken beq needs distinct operands
		if (imm_b == imm_a) begin
			imm_b = imm_a ^ 12'h001;
		end
		val_a      = {{20{imm_a[11]}}, imm_a};
		val_b      = {{20{imm_b[11]}}, imm_b};
		val_c      = {{20{imm_c[11]}}, imm_c};
		link_value = 32'(JAL_IDX * 4) + 32'd4;

		prog[0]  = addi_word(5'd1, 5'd0, imm_a);
		prog[1]  = addi_word(5'd2, 5'd0, imm_b);
		prog[2]  = alu_reg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
		prog[3]  = alu_reg(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
		prog[4]  = sw_word(5'd3, 5'd0, 12'h100);
		prog[5]  = sw_word(5'd4, 5'd0, 12'h104);
		prog[6]  = alu_reg(7'h00, 3'b111, 5'd5, 5'd1, 5'd2);
		prog[7]  = alu_reg(7'h00, 3'b110, 5'd6, 5'd1, 5'd2);
		prog[8]  = alu_reg(7'h00, 3'b100, 5'd7, 5'd5, 5'd6);
		prog[9]  = alu_reg(7'h00, 3'b010, 5'd8, 5'd1, 5'd2);
		prog[10] = sw_word(5'd5, 5'd0, 12'h108);
		prog[11] = sw_word(5'd6, 5'd0, 12'h10C);
		prog[12] = sw_word(5'd7, 5'd0, 12'h110);
		prog[13] = sw_word(5'd8, 5'd0, 12'h114);
		prog[14] = addi_word(5'd9, 5'd3, imm_c);
		prog[15] = sw_word(5'd9, 5'd0, 12'h118);
		prog[16] = alu_reg(7'h00, 3'b010, 5'd11, 5'd2, 5'd1);
		// load then immediate use
		prog[17] = lw_word(5'd10, 5'd0, 12'h100);
		prog[18] = alu_reg(7'h00, 3'b000, 5'd12, 5'd10, 5'd1);
		prog[19] = sw_word(5'd12, 5'd0, 12'h11C);
		// taken beq squashes 21 to 23 and jumps over 24
		// 22 would leave a value in x11 that no slt can produce
		prog[20] = beq_word(5'd1, 5'd1, 13'd20);
		prog[21] = sw_word(5'd1, 5'd0, 12'h180);
		prog[22] = addi_word(5'd11, 5'd0, 12'h0FF);
		prog[23] = sw_word(5'd2, 5'd0, 12'h184);
		prog[24] = sw_word(5'd1, 5'd0, 12'h188);
		prog[25] = beq_word(5'd1, 5'd2, 13'd8);
		prog[26] = sw_word(5'd11, 5'd0, 12'h120);
		prog[27] = jal_word(5'd14, 21'd12);
		prog[28] = sw_word(5'd1, 5'd0, 12'h18C);
		prog[29] = sw_word(5'd2, 5'd0, 12'h190);
		prog[30] = sw_word(5'd14, 5'd0, 12'h124);
		prog[31] = alu_reg(7'h20, 3'b000, 5'd15, 5'd14, 5'd1);
		prog[32] = sw_word(5'd15, 5'd0, 12'h128);
		for (int i = 0; i < ROM_WORDS; i++) begin
			if (i < PROG_LEN) begin
				u_mem.rom[i] = prog[i];
			end else begin
				u_mem.rom[i] = `RV_NOP;
			end
		end

		for (int i = 0; i < 16; i++) begin
			exp_addr[i] = '0;
			exp_data[i] = '0;
		end
		exp_addr[0]  = 32'h100;
		exp_data[0]  = val_a + val_b;
		exp_addr[1]  = 32'h104;
		exp_data[1]  = (val_a + val_b) - val_a;
		exp_addr[2]  = 32'h108;
		exp_data[2]  = val_a & val_b;
		exp_addr[3]  = 32'h10C;
		exp_data[3]  = val_a | val_b;
		exp_addr[4]  = 32'h110;
		exp_data[4]  = (val_a & val_b) ^ (val_a | val_b);
		exp_addr[5]  = 32'h114;
		exp_data[5]  = less_signed(val_a, val_b);
		exp_addr[6]  = 32'h118;
		exp_data[6]  = val_a + val_b + val_c;
		// loaded word is the first store
		exp_addr[7]  = 32'h11C;
		exp_data[7]  = (val_a + val_b) + val_a;
		exp_addr[8]  = 32'h120;
		exp_data[8]  = less_signed(val_b, val_a);
		exp_addr[9]  = 32'h124;
		exp_data[9]  = link_value;
		exp_addr[10] = 32'h128;
		exp_data[10] = link_value - val_a;

		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;
	end

	pc_after_reset: assert property (@(posedge clock)
		(reset && !$past(reset)) |-> instr_addr == `RV_RESET_PC)
		else report_failure($sformatf("first fetch address %h after reset",
			$sampled(instr_addr)));

	pc_sequence: assert property (@(posedge clock) disable iff (!reset)
		$past(reset) |-> (instr_addr == $past(instr_addr) + 32'd4 ||
		instr_addr == $past(instr_addr) || is_redirect_target(instr_addr)))
		else report_failure($sformatf("fetch address jumped to %h",
			$sampled(instr_addr)));

	strobes_exclusive: assert property (@(posedge clock) disable iff (!reset)
		!(data_ren && data_wen))
		else report_failure("data_ren and data_wen high in the same cycle");

	load_address: assert property (@(posedge clock) disable iff (!reset)
		data_ren |-> data_addr == LOAD_ADDR)
		else report_failure($sformatf("load from %h, expected %h",
			$sampled(data_addr), LOAD_ADDR));

	store_in_table: assert property (@(posedge clock) disable iff (!reset)
		data_wen |-> store_count < 4'(NUM_STORES))
		else report_failure($sformatf("extra store of %h to %h",
			$sampled(data_wdata), $sampled(data_addr)));

	store_matches: assert property (@(posedge clock) disable iff (!reset)
		data_wen |-> (data_addr == want_addr && data_wdata == want_data))
		else report_failure($sformatf("store %0d wrote %h to %h, expected %h to %h",
			$sampled(store_count), $sampled(data_wdata), $sampled(data_addr),
			$sampled(want_data), $sampled(want_addr)));

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired, the final store did not arrive within %0d cycles",
			WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	initial begin : finish_run
		wait (store_count == 4'(NUM_STORES));
		// a few more cycles so trailing strobes still get checked
		repeat (4) @(negedge clock);
		if (!failed) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== rv_core.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/rv_core.sv
dv/tb_memory.sv
dv/tb_rv_core.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_rv_core
FILELIST := rv_core.f
LOG      := sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
